// ==== common/soc_config.svh ====
//////////////////////////////////////////////////////////////////////
// Memory map, bus widths and sizes of the peripheral subsystem
// Included by the package and by every block that decodes addresses
//////////////////////////////////////////////////////////////////////

`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// Boot ROM region
`define SOC_BOOT_BASE  32'h0005_0000
`define SOC_BOOT_WORDS 16

// L2 SRAM region, 1 KiB
`define SOC_L2_BASE  32'h8000_0000
`define SOC_L2_WORDS 256

// Peripheral pages
`define SOC_UART_BASE  32'hC000_0000
`define SOC_CTRL_BASE  32'hD000_0000
`define SOC_PERIPH_LEN 32'h0000_1000

// Upper half of every ROM word
`define SOC_ROM_TAG 16'hB007

`endif

// ==== common/soc_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Bus types, structs and state encodings shared by RTL and testbench
//////////////////////////////////////////////////////////////////////

`include "soc_config.svh"

package soc_pkg;

  // Plain bus vectors
  typedef logic [`SOC_ADDR_W-1:0]   addr_t;
  typedef logic [`SOC_DATA_W-1:0]   data_t;
  typedef logic [`SOC_DATA_W/8-1:0] strb_t;

  // One internal access, handed from port to decoder to target
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    strb_t strb;
    logic  write;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // APB request and response bundles
  typedef struct packed {
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    data_t pwdata;
    strb_t pstrb;
  } apb_req_t;

  typedef struct packed {
    data_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  // Decoder targets
  typedef enum logic [2:0] {
    TGT_L2   = 3'd0,
    TGT_BOOT = 3'd1,
    TGT_CTRL = 3'd2,
    TGT_UART = 3'd3,
    TGT_NONE = 3'd4
  } target_e;

  typedef enum logic {
    PORT_IDLE = 1'b0,
    PORT_WAIT = 1'b1
  } port_state_e;

  typedef enum logic [1:0] {
    UART_IDLE   = 2'd0,
    UART_SETUP  = 2'd1,
    UART_ACCESS = 2'd2
  } uart_state_e;

endpackage : soc_pkg

// ==== mem/soc_l2_mem.sv ====
//////////////////////////////////////////////////////////////////////
// On-chip L2 SRAM, single port, byte strobes, one-cycle response
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "soc_config.svh"

module soc_l2_mem (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  soc_pkg::bus_req_t req_i,
  input  logic              valid_i,
  output soc_pkg::bus_rsp_t rsp_o,
  output logic              done_o
);

  import soc_pkg::*;

  localparam int unsigned IDX_W = $clog2(`SOC_L2_WORDS);

  data_t            mem [`SOC_L2_WORDS];
  data_t            rdata_q;
  logic [IDX_W-1:0] idx;

  // Word index inside the region
  assign idx = req_i.addr[IDX_W+1:2];

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      if (req_i.write) begin
        for (int b = 0; b < `SOC_DATA_W / 8; b++) begin
          if (req_i.strb[b]) mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= valid_i;
    end
  end

  assign rsp_o = '{rdata: rdata_q, err: 1'b0};

endmodule : soc_l2_mem

// ==== mem/soc_bootrom.sv ====
//////////////////////////////////////////////////////////////////////
// Boot ROM with generated contents, read only, one-cycle response
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "soc_config.svh"

module soc_bootrom (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  soc_pkg::bus_req_t req_i,
  input  logic              valid_i,
  output soc_pkg::bus_rsp_t rsp_o,
  output logic              done_o
);

  import soc_pkg::*;

  localparam int unsigned IDX_W = $clog2(`SOC_BOOT_WORDS);

  logic [IDX_W-1:0] idx;
  data_t            rdata_q;
  logic             err_q;

  // Upper index bits are dropped, so the ROM repeats over its page
  assign idx = req_i.addr[IDX_W+1:2];

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rdata_q <= req_i.write ? '0 : {`SOC_ROM_TAG, 16'(idx)};
      err_q   <= req_i.write;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= valid_i;
    end
  end

  assign rsp_o = '{rdata: rdata_q, err: err_q};

endmodule : soc_bootrom

// ==== src/soc_apb_port.sv ====
//////////////////////////////////////////////////////////////////////
// Host APB slave. Each transfer becomes one internal request and
// pready is raised when the matching response comes back
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module soc_apb_port (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  soc_pkg::apb_req_t apb_i,
  output soc_pkg::apb_rsp_t apb_o,
  output soc_pkg::bus_req_t req_o,
  output logic              req_valid_o,
  input  soc_pkg::bus_rsp_t rsp_i,
  input  logic              rsp_valid_i
);

  import soc_pkg::*;

  port_state_e state_q;
  port_state_e state_d;

  // Request fields come straight from the held host bus
  assign req_o.addr  = apb_i.paddr;
  assign req_o.wdata = apb_i.pwdata;
  assign req_o.strb  = apb_i.pstrb;
  assign req_o.write = apb_i.pwrite;

  // Fire once, in the first access cycle
  assign req_valid_o = (state_q == PORT_IDLE) && apb_i.psel && apb_i.penable;

  always_comb begin
    state_d = state_q;
    case (state_q)
      PORT_IDLE:
        if (req_valid_o) state_d = PORT_WAIT;
      PORT_WAIT:
        if (rsp_valid_i) state_d = PORT_IDLE;
      default: state_d = PORT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= PORT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Completion goes straight back to the host
  assign apb_o.pready  = rsp_valid_i;
  assign apb_o.prdata  = rsp_i.rdata;
  assign apb_o.pslverr = rsp_i.err;

endmodule : soc_apb_port

// ==== src/soc_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// Address decoder. Routes each request to one target and returns
// that target's response, or a slave error for unmapped addresses
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "soc_config.svh"

module soc_decoder (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  soc_pkg::bus_req_t req_i,
  input  logic              req_valid_i,
  output soc_pkg::bus_rsp_t rsp_o,
  output logic              rsp_valid_o,
  // Target selects
  output logic              l2_valid_o,
  output logic              boot_valid_o,
  output logic              ctrl_valid_o,
  output logic              uart_valid_o,
  // Target responses
  input  soc_pkg::bus_rsp_t l2_rsp_i,
  input  logic              l2_done_i,
  input  soc_pkg::bus_rsp_t boot_rsp_i,
  input  logic              boot_done_i,
  input  soc_pkg::bus_rsp_t ctrl_rsp_i,
  input  logic              ctrl_done_i,
  input  soc_pkg::bus_rsp_t uart_rsp_i,
  input  logic              uart_done_i
);

  import soc_pkg::*;

  localparam addr_t L2_LEN = addr_t'(`SOC_L2_WORDS * (`SOC_DATA_W / 8));

  target_e tgt;
  target_e sel_q;
  logic    none_q;

  // Offset compare avoids overflow at the top of the map
  function automatic logic in_region(addr_t addr, addr_t base, addr_t len);
    addr_t offs;
    offs = addr - base;
    return offs < len;
  endfunction

  // ROM decodes a whole page, words alias inside it
  always_comb begin
    if (in_region(req_i.addr, `SOC_L2_BASE, L2_LEN)) tgt = TGT_L2;
    else if (in_region(req_i.addr, `SOC_BOOT_BASE, `SOC_PERIPH_LEN)) tgt = TGT_BOOT;
    else if (in_region(req_i.addr, `SOC_CTRL_BASE, `SOC_PERIPH_LEN)) tgt = TGT_CTRL;
    else if (in_region(req_i.addr, `SOC_UART_BASE, `SOC_PERIPH_LEN)) tgt = TGT_UART;
    else tgt = TGT_NONE;
  end

  assign l2_valid_o   = req_valid_i && (tgt == TGT_L2);
  assign boot_valid_o = req_valid_i && (tgt == TGT_BOOT);
  assign ctrl_valid_o = req_valid_i && (tgt == TGT_CTRL);
  assign uart_valid_o = req_valid_i && (tgt == TGT_UART);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q  <= TGT_NONE;
      none_q <= 1'b0;
    end else begin
      if (req_valid_i) sel_q <= tgt;
      none_q <= req_valid_i && (tgt == TGT_NONE);
    end
  end

  // Response mux follows the target latched at request time
  always_comb begin
    rsp_o       = '{rdata: '0, err: 1'b1};
    rsp_valid_o = none_q;
    case (sel_q)
      TGT_L2: begin
        rsp_o       = l2_rsp_i;
        rsp_valid_o = l2_done_i;
      end
      TGT_BOOT: begin
        rsp_o       = boot_rsp_i;
        rsp_valid_o = boot_done_i;
      end
      TGT_CTRL: begin
        rsp_o       = ctrl_rsp_i;
        rsp_valid_o = ctrl_done_i;
      end
      TGT_UART: begin
        rsp_o       = uart_rsp_i;
        rsp_valid_o = uart_done_i;
      end
      default: ;
    endcase
  end

endmodule : soc_decoder

// ==== src/soc_ctrl_regs.sv ====
//////////////////////////////////////////////////////////////////////
// SoC control and status registers behind the CTRL page, driving the
// exit, DRAM window, event and counter enable outputs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "soc_config.svh"

module soc_ctrl_regs (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  soc_pkg::bus_req_t req_i,
  input  logic              valid_i,
  output soc_pkg::bus_rsp_t rsp_o,
  output logic              done_o,
  // CSRs
  output soc_pkg::data_t    exit_o,
  output soc_pkg::data_t    dram_base_addr_o,
  output soc_pkg::data_t    dram_end_addr_o,
  output soc_pkg::data_t    event_trigger_o,
  output soc_pkg::data_t    hw_cnt_en_o
);

  import soc_pkg::*;

  localparam int unsigned OFF_W = $clog2(`SOC_PERIPH_LEN);

  // Register offsets
  localparam logic [OFF_W-1:0] OFF_EXIT      = 'h0;
  localparam logic [OFF_W-1:0] OFF_DRAM_BASE = 'h4;
  localparam logic [OFF_W-1:0] OFF_DRAM_END  = 'h8;
  localparam logic [OFF_W-1:0] OFF_EVENT     = 'hC;
  localparam logic [OFF_W-1:0] OFF_CNT_EN    = 'h10;

  // DRAM window is the L2 region
  localparam data_t DRAM_BASE = `SOC_L2_BASE;
  localparam data_t DRAM_END  = DRAM_BASE + data_t'(`SOC_L2_WORDS * (`SOC_DATA_W / 8));

  logic [OFF_W-1:0] offset;
  data_t            exit_q;
  data_t            event_q;
  data_t            cnt_en_q;
  data_t            rdata_d;
  data_t            rdata_q;
  logic             err_d;
  logic             err_q;

  function automatic data_t merge_bytes(data_t old_val, data_t new_val, strb_t strb);
    data_t res;
    res = old_val;
    for (int b = 0; b < `SOC_DATA_W / 8; b++) begin
      if (strb[b]) res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

  assign offset = req_i.addr[OFF_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // Response decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    case (offset)
      OFF_EXIT:      rdata_d = exit_q;
      OFF_EVENT:     rdata_d = event_q;
      OFF_CNT_EN:    rdata_d = cnt_en_q;
      OFF_DRAM_BASE: begin
        rdata_d = DRAM_BASE;
        err_d   = req_i.write;
      end
      OFF_DRAM_END: begin
        rdata_d = DRAM_END;
        err_d   = req_i.write;
      end
      default: err_d = 1'b1;
    endcase
    // writes answer with zero data
    if (req_i.write) rdata_d = '0;
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rdata_q <= rdata_d;
      err_q   <= err_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Writable registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_q   <= '0;
      event_q  <= '0;
      cnt_en_q <= '0;
      done_o   <= 1'b0;
    end else begin
      done_o <= valid_i;
      if (valid_i && req_i.write) begin
        case (offset)
          OFF_EXIT:   exit_q   <= merge_bytes(exit_q, req_i.wdata, req_i.strb);
          OFF_EVENT:  event_q  <= merge_bytes(event_q, req_i.wdata, req_i.strb);
          OFF_CNT_EN: cnt_en_q <= merge_bytes(cnt_en_q, req_i.wdata, req_i.strb);
          default: ;
        endcase
      end
    end
  end

  assign rsp_o = '{rdata: rdata_q, err: err_q};

  assign exit_o           = exit_q;
  assign dram_base_addr_o = DRAM_BASE;
  assign dram_end_addr_o  = DRAM_END;
  assign event_trigger_o  = event_q;
  assign hw_cnt_en_o      = cnt_en_q;

endmodule : soc_ctrl_regs

// ==== src/soc_uart_bridge.sv ====
//////////////////////////////////////////////////////////////////////
// APB master that replays UART page requests on the outgoing port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module soc_uart_bridge (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  soc_pkg::bus_req_t req_i,
  input  logic              valid_i,
  output soc_pkg::apb_req_t apb_o,
  input  soc_pkg::apb_rsp_t apb_i,
  output soc_pkg::bus_rsp_t rsp_o,
  output logic              done_o
);

  import soc_pkg::*;

  uart_state_e state_q;
  uart_state_e state_d;
  bus_req_t    req_q;

  // Setup, then access until the slave is ready
  always_comb begin
    state_d = state_q;
    case (state_q)
      UART_IDLE:
        if (valid_i) state_d = UART_SETUP;
      UART_SETUP: state_d = UART_ACCESS;
      UART_ACCESS:
        if (apb_i.pready) state_d = UART_IDLE;
      default: state_d = UART_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= UART_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request held for the whole transfer
  always_ff @(posedge clk_i) begin
    if ((state_q == UART_IDLE) && valid_i) req_q <= req_i;
  end

  // Address goes out unchanged
  assign apb_o.psel    = (state_q != UART_IDLE);
  assign apb_o.penable = (state_q == UART_ACCESS);
  assign apb_o.pwrite  = req_q.write;
  assign apb_o.paddr   = req_q.addr;
  assign apb_o.pwdata  = req_q.wdata;
  assign apb_o.pstrb   = req_q.strb;

  assign done_o = (state_q == UART_ACCESS) && apb_i.pready;
  assign rsp_o  = '{rdata: apb_i.prdata, err: apb_i.pslverr};

endmodule : soc_uart_bridge

// ==== src/soc_top.sv ====
//////////////////////////////////////////////////////////////////////
// Peripheral subsystem top level that connects the host APB port, the
// address decoder, memories, control registers and the UART APB bridge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module soc_top (
  input  logic              clk_i,
  input  logic              arst_n_i,
  // Host side
  input  soc_pkg::apb_req_t host_apb_i,
  output soc_pkg::apb_rsp_t host_apb_o,
  // UART side
  output soc_pkg::apb_req_t uart_apb_o,
  input  soc_pkg::apb_rsp_t uart_apb_i,
  // CSRs
  output soc_pkg::data_t    exit_o,
  output soc_pkg::data_t    dram_base_addr_o,
  output soc_pkg::data_t    dram_end_addr_o,
  output soc_pkg::data_t    event_trigger_o,
  output soc_pkg::data_t    hw_cnt_en_o
);

  import soc_pkg::*;

  bus_req_t req;
  logic     req_valid;
  bus_rsp_t rsp;
  logic     rsp_valid;

  // Per target valid, response and done
  logic     l2_valid;
  logic     boot_valid;
  logic     ctrl_valid;
  logic     uart_valid;
  bus_rsp_t l2_rsp;
  bus_rsp_t boot_rsp;
  bus_rsp_t ctrl_rsp;
  bus_rsp_t uart_rsp;
  logic     l2_done;
  logic     boot_done;
  logic     ctrl_done;
  logic     uart_done;

  //////////////////////////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////////////////////////

  soc_apb_port i_apb_port (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .apb_i       (host_apb_i),
    .apb_o       (host_apb_o),
    .req_o       (req),
    .req_valid_o (req_valid),
    .rsp_i       (rsp),
    .rsp_valid_i (rsp_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // Decode and memory-mapped targets
  //////////////////////////////////////////////////////////////////////

  soc_decoder i_decoder (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (req),
    .req_valid_i  (req_valid),
    .rsp_o        (rsp),
    .rsp_valid_o  (rsp_valid),
    .l2_valid_o   (l2_valid),
    .boot_valid_o (boot_valid),
    .ctrl_valid_o (ctrl_valid),
    .uart_valid_o (uart_valid),
    .l2_rsp_i     (l2_rsp),
    .l2_done_i    (l2_done),
    .boot_rsp_i   (boot_rsp),
    .boot_done_i  (boot_done),
    .ctrl_rsp_i   (ctrl_rsp),
    .ctrl_done_i  (ctrl_done),
    .uart_rsp_i   (uart_rsp),
    .uart_done_i  (uart_done)
  );

  soc_l2_mem i_l2_mem (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (req),
    .valid_i  (l2_valid),
    .rsp_o    (l2_rsp),
    .done_o   (l2_done)
  );

  soc_bootrom i_bootrom (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (req),
    .valid_i  (boot_valid),
    .rsp_o    (boot_rsp),
    .done_o   (boot_done)
  );

  //////////////////////////////////////////////////////////////////////
  // Output side
  //////////////////////////////////////////////////////////////////////

  soc_ctrl_regs i_ctrl_regs (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .req_i            (req),
    .valid_i          (ctrl_valid),
    .rsp_o            (ctrl_rsp),
    .done_o           (ctrl_done),
    .exit_o           (exit_o),
    .dram_base_addr_o (dram_base_addr_o),
    .dram_end_addr_o  (dram_end_addr_o),
    .event_trigger_o  (event_trigger_o),
    .hw_cnt_en_o      (hw_cnt_en_o)
  );

  soc_uart_bridge i_uart_bridge (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (req),
    .valid_i  (uart_valid),
    .apb_o    (uart_apb_o),
    .apb_i    (uart_apb_i),
    .rsp_o    (uart_rsp),
    .done_o   (uart_done)
  );

endmodule : soc_top

// ==== tb/soc_sva.sv ====
//////////////////////////////////////////////////////////////////////
// Protocol assertions on the host and UART APB ports, bound to soc_top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module soc_sva (
  input logic              clk_i,
  input logic              arst_n_i,
  input soc_pkg::apb_req_t host_apb_i,
  input soc_pkg::apb_rsp_t host_apb_o,
  input soc_pkg::apb_req_t uart_apb_o,
  input soc_pkg::apb_rsp_t uart_apb_i,
  input soc_pkg::data_t    exit_o,
  input soc_pkg::data_t    dram_base_addr_o,
  input soc_pkg::data_t    dram_end_addr_o,
  input soc_pkg::data_t    event_trigger_o,
  input soc_pkg::data_t    hw_cnt_en_o
);

  import soc_pkg::*;

  // Host completion only inside an access phase
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    host_apb_o.pready |-> (host_apb_i.psel && host_apb_i.penable))
    else $error("host pready raised outside an APB access phase");

  // UART request held until the slave completes it
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (uart_apb_o.psel && !(uart_apb_o.penable && uart_apb_i.pready))
    |=> (uart_apb_o.psel && $stable(uart_apb_o.paddr)))
    else $error("UART psel or paddr changed before pready");

  assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> (!uart_apb_o.psel && !uart_apb_o.penable &&
      !$isunknown({exit_o, dram_base_addr_o, dram_end_addr_o,
                   event_trigger_o, hw_cnt_en_o})))
    else $error("UART port busy or CSR outputs unknown after reset");

endmodule : soc_sva

bind soc_top soc_sva u_soc_sva (
  .clk_i            (clk_i),
  .arst_n_i         (arst_n_i),
  .host_apb_i       (host_apb_i),
  .host_apb_o       (host_apb_o),
  .uart_apb_o       (uart_apb_o),
  .uart_apb_i       (uart_apb_i),
  .exit_o           (exit_o),
  .dram_base_addr_o (dram_base_addr_o),
  .dram_end_addr_o  (dram_end_addr_o),
  .event_trigger_o  (event_trigger_o),
  .hw_cnt_en_o      (hw_cnt_en_o)
);

// ==== tb/tb_soc.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the peripheral subsystem. Drives the host APB port from
// a table of accesses and models a UART APB slave with wait states
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "soc_config.svh"

module tb_soc;

  import soc_pkg::*;

  localparam int    RESET_CYCLES = 8;
  localparam data_t UART_MASK    = 32'h5A5A_5A5A;
  // L2 is 1 KiB long
  localparam data_t DRAM_END     = `SOC_L2_BASE + 32'h0000_0400;

  typedef struct {
    string name;
    addr_t addr;
    logic  write;
    data_t wdata;
    strb_t strb;
    data_t rdata;
    logic  err;
  } test_t;

  logic     clk;
  logic     arst_n;
  apb_req_t host_apb;
  apb_rsp_t host_rsp;
  apb_req_t uart_req;
  apb_rsp_t uart_rsp = '0;
  data_t    exit_val;
  data_t    dram_base;
  data_t    dram_end;
  data_t    event_val;
  data_t    cnt_en;

  test_t       tests[$];
  int          timeout_limit = 0;
  int          cycles = 0;
  // UART slave model state
  int unsigned uart_xfers = 0;
  int unsigned wait_left = 0;
  addr_t       uart_last_addr = '0;
  data_t       uart_last_wdata = '0;
  strb_t       uart_last_strb = '0;
  logic        uart_last_write = 1'b0;

  soc_top u_soc_top (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .host_apb_i       (host_apb),
    .host_apb_o       (host_rsp),
    .uart_apb_o       (uart_req),
    .uart_apb_i       (uart_rsp),
    .exit_o           (exit_val),
    .dram_base_addr_o (dram_base),
    .dram_end_addr_o  (dram_end),
    .event_trigger_o  (event_val),
    .hw_cnt_en_o      (cnt_en)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "stopping after the first error");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      fail_run($sformatf("mismatch %s addr: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_strb(input string name, input strb_t exp, input strb_t act);
    if (act !== exp) begin
      fail_run($sformatf("mismatch %s pstrb: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("mismatch %s err: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_write(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("mismatch %s pwrite: expected %b, actual %b", name, exp, act));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////

  task automatic add_test(input string name, input addr_t addr, input logic write,
                          input data_t wdata, input strb_t strb, input data_t rdata,
                          input logic err);
    test_t t;
    t = '{name: name, addr: addr, write: write, wdata: wdata, strb: strb,
          rdata: rdata, err: err};
    tests.push_back(t);
  endtask

  task automatic load_tests();
    // Byte merge on L2
    add_test("l2_wr_full", 32'h8000_0010, 1'b1, 32'hDEAD_BEEF, 4'hF, '0, 1'b0);
    add_test("l2_wr_part", 32'h8000_0010, 1'b1, 32'h1122_3344, 4'h5, '0, 1'b0);
    add_test("l2_rd_merge", 32'h8000_0010, 1'b0, '0, 4'hF, 32'hDE22_BE44, 1'b0);
    add_test("l2_wr_top", 32'h8000_03FC, 1'b1, 32'hCAFE_F00D, 4'hF, '0, 1'b0);
    add_test("l2_rd_top", 32'h8000_03FC, 1'b0, '0, 4'hF, 32'hCAFE_F00D, 1'b0);
    // ROM words carry the tag and their index
    add_test("rom_rd_0", 32'h0005_0000, 1'b0, '0, 4'hF, {`SOC_ROM_TAG, 16'd0}, 1'b0);
    add_test("rom_rd_5", 32'h0005_0014, 1'b0, '0, 4'hF, {`SOC_ROM_TAG, 16'd5}, 1'b0);
    add_test("rom_rd_15", 32'h0005_003C, 1'b0, '0, 4'hF, {`SOC_ROM_TAG, 16'd15}, 1'b0);
    add_test("rom_rd_alias", 32'h0005_0044, 1'b0, '0, 4'hF, {`SOC_ROM_TAG, 16'd1}, 1'b0);
    add_test("rom_wr", 32'h0005_0008, 1'b1, 32'h1234_5678, 4'hF, '0, 1'b1);
    // Control register reset values come first
    add_test("ctrl_exit_rst", 32'hD000_0000, 1'b0, '0, 4'hF, '0, 1'b0);
    add_test("ctrl_base_rst", 32'hD000_0004, 1'b0, '0, 4'hF, `SOC_L2_BASE, 1'b0);
    add_test("ctrl_end_rst", 32'hD000_0008, 1'b0, '0, 4'hF, DRAM_END, 1'b0);
    add_test("ctrl_event_rst", 32'hD000_000C, 1'b0, '0, 4'hF, '0, 1'b0);
    add_test("ctrl_cnt_rst", 32'hD000_0010, 1'b0, '0, 4'hF, '0, 1'b0);
    add_test("ctrl_wr_exit", 32'hD000_0000, 1'b1, 32'h0000_00FF, 4'hF, '0, 1'b0);
    add_test("ctrl_wr_event", 32'hD000_000C, 1'b1, 32'h1234_5678, 4'h3, '0, 1'b0);
    add_test("ctrl_wr_cnt", 32'hD000_0010, 1'b1, 32'h0000_0001, 4'h1, '0, 1'b0);
    add_test("ctrl_rd_exit", 32'hD000_0000, 1'b0, '0, 4'hF, 32'h0000_00FF, 1'b0);
    add_test("ctrl_rd_event", 32'hD000_000C, 1'b0, '0, 4'hF, 32'h0000_5678, 1'b0);
    add_test("ctrl_rd_cnt", 32'hD000_0010, 1'b0, '0, 4'hF, 32'h0000_0001, 1'b0);
    add_test("ctrl_wr_base", 32'hD000_0004, 1'b1, 32'hFFFF_FFFF, 4'hF, '0, 1'b1);
    add_test("ctrl_rd_bad", 32'hD000_0020, 1'b0, '0, 4'hF, '0, 1'b1);
    add_test("ctrl_wr_bad", 32'hD000_0020, 1'b1, 32'h0000_0001, 4'hF, '0, 1'b1);
    // UART page errors when address bit 2 is set
    add_test("uart_rd_ok", 32'hC000_0000, 1'b0, '0, 4'hF, 32'hC000_0000 ^ UART_MASK, 1'b0);
    add_test("uart_rd_err", 32'hC000_0004, 1'b0, '0, 4'hF, 32'hC000_0004 ^ UART_MASK, 1'b1);
    add_test("uart_wr_ok", 32'hC000_0008, 1'b1, 32'h0000_00A5, 4'h1, '0, 1'b0);
    add_test("uart_wr_err", 32'hC000_000C, 1'b1, 32'h0000_005A, 4'hF, '0, 1'b1);
    add_test("uart_rd_hi", 32'hC000_0FF0, 1'b0, '0, 4'hF, 32'hC000_0FF0 ^ UART_MASK, 1'b0);
    // Unmapped, then prove nothing else moved
    add_test("unmapped_rd", 32'h4000_0000, 1'b0, '0, 4'hF, '0, 1'b1);
    add_test("unmapped_wr", 32'h4000_0010, 1'b1, 32'hFFFF_FFFF, 4'hF, '0, 1'b1);
    add_test("l2_rd_after", 32'h8000_0010, 1'b0, '0, 4'hF, 32'hDE22_BE44, 1'b0);
    add_test("ctrl_exit_after", 32'hD000_0000, 1'b0, '0, 4'hF, 32'h0000_00FF, 1'b0);
  endtask

  function automatic logic in_uart_page(addr_t addr);
    addr_t offs;
    offs = addr - `SOC_UART_BASE;
    return offs < `SOC_PERIPH_LEN;
  endfunction

  // One APB transfer with setup, access and a hold until pready
  task automatic apb_access(input test_t t, output data_t rdata, output logic err);
    @(posedge clk);
    host_apb <= '{psel: 1'b1, penable: 1'b0, pwrite: t.write, paddr: t.addr,
                  pwdata: t.wdata, pstrb: t.strb};
    @(posedge clk);
    host_apb.penable <= 1'b1;
    do begin
      @(negedge clk);
    end while (!host_rsp.pready);
    rdata = host_rsp.prdata;
    err   = host_rsp.pslverr;
    @(posedge clk);
    host_apb <= '0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // UART slave model
  //////////////////////////////////////////////////////////////////////

  function automatic apb_rsp_t uart_reply(apb_req_t r);
    apb_rsp_t rsp;
    rsp.prdata  = r.pwrite ? '0 : (r.paddr ^ UART_MASK);
    rsp.pready  = 1'b1;
    rsp.pslverr = r.paddr[2];
    return rsp;
  endfunction

  // Draws 0 to 3 wait states in the setup cycle
  always @(posedge clk) begin
    int unsigned draw;
    if (uart_rsp.pready) begin
      uart_rsp <= '0;
    end else if (uart_req.psel && !uart_req.penable) begin
      draw = $urandom % 4;
      uart_xfers      <= uart_xfers + 1;
      uart_last_addr  <= uart_req.paddr;
      uart_last_wdata <= uart_req.pwdata;
      uart_last_strb  <= uart_req.pstrb;
      uart_last_write <= uart_req.pwrite;
      if (draw == 0) uart_rsp <= uart_reply(uart_req);
      else wait_left <= draw;
    end else if (uart_req.psel && uart_req.penable) begin
      if (wait_left < 2) uart_rsp <= uart_reply(uart_req);
      else wait_left <= wait_left - 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_limit) begin
      fail_run($sformatf("timeout: the run did not finish within %0d cycles", cycles));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    data_t       rdata;
    logic        err;
    int unsigned xfers_before;
    void'($urandom(32'h1583));
    host_apb = '0;
    arst_n   = 1'b0;
    load_tests();
    timeout_limit = tests.size() * 10 + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_data("exit_o_rst", '0, exit_val);
    check_data("dram_base_rst", `SOC_L2_BASE, dram_base);
    check_data("dram_end_rst", DRAM_END, dram_end);
    check_data("event_rst", '0, event_val);
    check_data("cnt_en_rst", '0, cnt_en);

    foreach (tests[i]) begin
      xfers_before = uart_xfers;
      apb_access(tests[i], rdata, err);
      check_data(tests[i].name, tests[i].rdata, rdata);
      check_err(tests[i].name, tests[i].err, err);
      if (in_uart_page(tests[i].addr)) begin
        if (uart_xfers != xfers_before + 1) begin
          fail_run($sformatf("%s never showed up on the UART port", tests[i].name));
        end
        check_addr(tests[i].name, tests[i].addr, uart_last_addr);
        check_write(tests[i].name, tests[i].write, uart_last_write);
        if (tests[i].write) begin
          check_data(tests[i].name, tests[i].wdata, uart_last_wdata);
          check_strb(tests[i].name, tests[i].strb, uart_last_strb);
        end
      end else if (uart_xfers != xfers_before) begin
        fail_run($sformatf("%s leaked onto the UART port", tests[i].name));
      end
    end

    // CSR outputs after the writes and the unmapped accesses
    @(negedge clk);
    check_data("exit_o", 32'h0000_00FF, exit_val);
    check_data("dram_base_o", `SOC_L2_BASE, dram_base);
    check_data("dram_end_o", DRAM_END, dram_end);
    check_data("event_o", 32'h0000_5678, event_val);
    check_data("cnt_en_o", 32'h0000_0001, cnt_en);
    $display("=== PASS ===");
    $finish;
  end

endmodule : tb_soc

// ==== build.f ====
+incdir+common
common/soc_pkg.sv
mem/soc_l2_mem.sv
mem/soc_bootrom.sv
src/soc_apb_port.sv
src/soc_decoder.sv
src/soc_ctrl_regs.sv
src/soc_uart_bridge.sv
src/soc_top.sv
tb/soc_sva.sv
tb/tb_soc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; exit status reports pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_soc -f build.f -o tb_soc_sim \
  && ./obj_dir/tb_soc_sim \
  || { echo "simulation failed"; exit 1; }
